//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;      // Address, data and instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type funct codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_SLT
    } alu_op_t;

endpackage

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    input  cpu_pkg::alu_op_t  op,
    output cpu_pkg::word_t    result,
    output logic              zero
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;       // Wraps, no trap
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            default:          result = a + b;
        endcase
    end

    assign zero = (result == 32'b0);

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                clk,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    input  cpu_pkg::reg_addr_t  wr_addr,
    input  logic                wr_en,
    input  cpu_pkg::word_t      wr_data,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 is hardwired
    assign rs_data = (rs_addr == 5'd0) ? 32'b0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'b0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- apb_master.sv
`timescale 1ns/1ns
`default_nettype none

module apb_master (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_req,
    input  logic            mem_write,
    input  cpu_pkg::word_t  mem_addr,
    input  cpu_pkg::word_t  mem_wdata,
    output logic            mem_done,
    output cpu_pkg::word_t  mem_rdata,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output cpu_pkg::word_t  paddr,
    output cpu_pkg::word_t  pwdata,
    input  cpu_pkg::word_t  prdata,
    input  logic            pready
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

    apb_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            pwrite   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (mem_req) begin
                        state  <= SETUP;
                        pwrite <= mem_write;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (pready) begin
                        state    <= IDLE;
                        mem_done <= 1'b1;   // Lines up with mem_rdata
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && mem_req) begin
            paddr  <= mem_addr;
            pwdata <= mem_wdata;
        end
        if (state == ACCESS && pready) begin
            mem_rdata <= prdata;
        end
    end

    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);

    // Slave may stretch access, payload must not move
    apb_hold: assert property (@(posedge clk) disable iff (reset)
        penable && !pready |=> $stable(paddr) && $stable(pwdata));

endmodule

`default_nettype wire

//--- control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_t  opcode,
    input  cpu_pkg::funct_t   funct,
    input  logic              mem_done,
    output logic              mem_req,
    output logic              mem_write,
    output logic              pc_load,
    output logic              branch_en,
    output logic              ir_load,
    output logic              ab_load,
    output logic              aluout_load,
    output logic              mdr_load,
    output logic              addr_from_alu,
    output logic              alu_src_a_reg,
    output logic              pc_from_jump,
    output logic              reg_write_en,
    output logic              reg_write_src_mem,
    output logic              reg_dst_rd,
    output logic [1:0]        alu_src_b,
    output cpu_pkg::alu_op_t  alu_op
);

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXEC,
        ALU_WB,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        LOAD_WB,
        BRANCH,
        JUMP
    } state_t;

    state_t state;
    state_t state_next;
    logic is_rtype;
    logic funct_kept;
    cpu_pkg::alu_op_t rtype_op;

    assign is_rtype = (opcode == cpu_pkg::OP_RTYPE);

    always_comb begin
        funct_kept = 1'b1;
        case (funct)
            cpu_pkg::FN_ADD: rtype_op = cpu_pkg::ALU_ADD;
            cpu_pkg::FN_SUB: rtype_op = cpu_pkg::ALU_SUB;
            cpu_pkg::FN_AND: rtype_op = cpu_pkg::ALU_AND;
            cpu_pkg::FN_SLT: rtype_op = cpu_pkg::ALU_SLT;
            default: begin
                rtype_op = cpu_pkg::ALU_ADD;
                funct_kept = 1'b0;      // Runs as a no-op
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       state_next = FETCH;
            FETCH:      state_next = FETCH_WAIT;
            FETCH_WAIT: if (mem_done) state_next = DECODE;
            DECODE: begin
                case (opcode)
                    cpu_pkg::OP_RTYPE:         state_next = funct_kept ? EXEC : FETCH;
                    cpu_pkg::OP_ADDI:          state_next = EXEC;
                    cpu_pkg::OP_LW, cpu_pkg::OP_SW: state_next = MEM_ADDR;
                    cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: state_next = BRANCH;
                    cpu_pkg::OP_J:             state_next = JUMP;
                    default:                   state_next = FETCH;
                endcase
            end
            EXEC:       state_next = ALU_WB;
            MEM_ADDR:   state_next = (opcode == cpu_pkg::OP_SW) ? MEM_WRITE : MEM_READ;
            MEM_READ:   if (mem_done) state_next = LOAD_WB;
            MEM_WRITE:  if (mem_done) state_next = FETCH;
            default:    state_next = FETCH;   // ALU_WB, LOAD_WB, BRANCH, JUMP
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        mem_req           = 1'b0;
        mem_write         = 1'b0;
        pc_load           = 1'b0;
        branch_en         = 1'b0;
        ir_load           = 1'b0;
        ab_load           = 1'b0;
        aluout_load       = 1'b0;
        mdr_load          = 1'b0;
        addr_from_alu     = 1'b0;
        alu_src_a_reg     = 1'b0;
        pc_from_jump      = 1'b0;
        reg_write_en      = 1'b0;
        reg_write_src_mem = 1'b0;
        reg_dst_rd        = 1'b0;
        alu_src_b         = 2'd1;
        alu_op            = cpu_pkg::ALU_ADD;
        case (state)
            FETCH: begin
                mem_req = 1'b1;
                pc_load = 1'b1;             // PC + 4 through the ALU
            end
            FETCH_WAIT: ir_load = mem_done;
            DECODE: begin
                ab_load     = 1'b1;
                aluout_load = 1'b1;         // Branch target
                alu_src_b   = 2'd3;
            end
            EXEC: begin
                alu_src_a_reg = 1'b1;
                alu_src_b     = is_rtype ? 2'd0 : 2'd2;
                alu_op        = is_rtype ? rtype_op : cpu_pkg::ALU_ADD;
                aluout_load   = 1'b1;
            end
            ALU_WB: begin
                reg_write_en = 1'b1;
                reg_dst_rd   = is_rtype;
            end
            MEM_ADDR, MEM_READ, MEM_WRITE: begin
                alu_src_a_reg = 1'b1;
                alu_src_b     = 2'd2;
                addr_from_alu = 1'b1;       // Address stays on the ALU output
                mem_req       = (state == MEM_ADDR);
                mem_write     = (state == MEM_ADDR) && (opcode == cpu_pkg::OP_SW);
                mdr_load      = (state == MEM_READ) && mem_done;
            end
            LOAD_WB: begin
                reg_write_en      = 1'b1;
                reg_write_src_mem = 1'b1;
            end
            BRANCH: begin
                alu_src_a_reg = 1'b1;
                alu_src_b     = 2'd0;
                alu_op        = cpu_pkg::ALU_SUB;
                branch_en     = 1'b1;
            end
            JUMP: begin
                pc_load      = 1'b1;
                pc_from_jump = 1'b1;
            end
            default: ;
        endcase
    end

    // Request is a lone pulse from a request state
    req_pulse: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> (state == FETCH || state == MEM_ADDR) ##1 !mem_req);

    no_write_clash: assert property (@(posedge clk) disable iff (reset)
        !(reg_write_en && mem_write));

endmodule

`default_nettype wire

//--- datapath_regs.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_regs #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                pc_load,
    input  logic                branch_en,
    input  logic                ir_load,
    input  logic                ab_load,
    input  logic                aluout_load,
    input  logic                mdr_load,
    input  logic                addr_from_alu,
    input  logic                alu_src_a_reg,
    input  logic [1:0]          alu_src_b,
    input  logic                pc_from_jump,
    input  logic                reg_write_src_mem,
    input  logic                reg_dst_rd,
    input  cpu_pkg::word_t      mem_rdata,
    input  cpu_pkg::word_t      alu_result,
    input  cpu_pkg::word_t      rs_data,
    input  cpu_pkg::word_t      rt_data,
    input  logic                zero,
    output cpu_pkg::opcode_t    opcode,
    output cpu_pkg::funct_t     funct,
    output cpu_pkg::reg_addr_t  rs_addr,
    output cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::reg_addr_t  wr_addr,
    output cpu_pkg::word_t      wr_data,
    output cpu_pkg::word_t      alu_a,
    output cpu_pkg::word_t      alu_b,
    output cpu_pkg::word_t      mem_addr,
    output cpu_pkg::word_t      mem_wdata
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t ir;
    cpu_pkg::word_t a_reg;
    cpu_pkg::word_t b_reg;
    cpu_pkg::word_t aluout;
    cpu_pkg::word_t mdr;
    cpu_pkg::word_t imm_ext;
    cpu_pkg::word_t jump_target;
    cpu_pkg::word_t pc_next;
    logic branch_taken;

    // Instruction fields
    assign opcode  = ir[31:26];
    assign funct   = ir[5:0];
    assign rs_addr = ir[25:21];
    assign rt_addr = ir[20:16];
    assign wr_addr = reg_dst_rd ? ir[15:11] : ir[20:16];
    assign wr_data = reg_write_src_mem ? mdr : aluout;

    assign imm_ext     = {{16{ir[15]}}, ir[15:0]};
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};  // pc already advanced

    assign alu_a = alu_src_a_reg ? a_reg : pc;

    always_comb begin
        case (alu_src_b)
            2'd0:    alu_b = b_reg;
            2'd1:    alu_b = 32'd4;
            2'd2:    alu_b = imm_ext;
            default: alu_b = {imm_ext[29:0], 2'b00};     // Branch offset
        endcase
    end

    assign mem_addr  = addr_from_alu ? alu_result : pc;
    assign mem_wdata = b_reg;

    // beq takes on zero, bne on nonzero
    assign branch_taken = branch_en && (zero == (opcode == cpu_pkg::OP_BEQ));

    always_comb begin
        if (pc_from_jump) begin
            pc_next = jump_target;
        end else if (branch_en) begin
            pc_next = aluout;
        end else begin
            pc_next = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_load || branch_taken) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) ir <= mem_rdata;
        if (ab_load) begin
            a_reg <= rs_data;
            b_reg <= rt_data;
        end
        if (aluout_load) aluout <= alu_result;
        if (mdr_load) mdr <= mem_rdata;
    end

endmodule

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0
) (
    input  logic            clk,
    input  logic            reset,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output cpu_pkg::word_t  paddr,
    output cpu_pkg::word_t  pwdata,
    input  cpu_pkg::word_t  prdata,
    input  logic            pready
);

    // Control to datapath and memory port
    logic mem_req, mem_write, mem_done;
    logic pc_load, branch_en, ir_load, ab_load, aluout_load, mdr_load;
    logic addr_from_alu, alu_src_a_reg, pc_from_jump;
    logic reg_write_en, reg_write_src_mem, reg_dst_rd;
    logic [1:0] alu_src_b;
    cpu_pkg::alu_op_t alu_op;

    cpu_pkg::opcode_t opcode;
    cpu_pkg::funct_t funct;
    cpu_pkg::reg_addr_t rs_addr, rt_addr, wr_addr;
    cpu_pkg::word_t rs_data, rt_data, wr_data;
    cpu_pkg::word_t alu_a, alu_b, alu_result;
    logic zero;
    cpu_pkg::word_t mem_addr, mem_wdata, mem_rdata;

    control_fsm u_control (.*);

    datapath_regs #(
        .RESET_PC(RESET_PC)
    ) u_datapath (.*);

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    reg_file u_regs (
        .clk     (clk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_addr (wr_addr),
        .wr_en   (reg_write_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    apb_master u_apb (.*);

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0,
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  cpu_pkg::word_t  paddr,
    input  cpu_pkg::word_t  pwdata,
    input  logic            pready,
    input  cpu_pkg::word_t  image [MEM_WORDS],
    input  logic [2:0]      tags [MEM_WORDS],
    output logic            done,
    output logic            timed_out,
    output int              error_count,
    output int              check_count
);

    cpu_pkg::word_t m_regs [32];
    cpu_pkg::word_t m_mem [MEM_WORDS];
    cpu_pkg::word_t m_pc;

    cpu_pkg::word_t exp_addr [$];
    logic exp_write [$];
    cpu_pkg::word_t exp_data [$];
    logic [2:0] exp_tag [$];

    int checks [7];
    int errs [7];
    int total, seen, cycles, waits;
    logic built, stalled, hold_write;
    cpu_pkg::word_t hold_addr, hold_data;

    function automatic void push(cpu_pkg::word_t a, logic w, cpu_pkg::word_t d, logic [2:0] t);
        exp_addr.push_back(a);
        exp_write.push_back(w);
        exp_data.push_back(d);
        exp_tag.push_back(t);
    endfunction

    // Runs one instruction, queues its transfers, returns 1 on a jump to itself
    function automatic logic step_model();
        cpu_pkg::word_t pc0, ir, rs_v, rt_v, imm, addr, res;
        logic [2:0] tag;
        int dst;
        pc0  = m_pc;
        ir   = m_mem[pc0[9:2]];
        tag  = tags[pc0[9:2]];
        rs_v = m_regs[ir[25:21]];
        rt_v = m_regs[ir[20:16]];
        imm  = {{16{ir[15]}}, ir[15:0]};
        addr = rs_v + imm;
        dst  = 0;
        res  = '0;
        push(pc0, 1'b0, '0, tag);
        m_pc = pc0 + 32'd4;
        case (ir[31:26])
            cpu_pkg::OP_RTYPE: begin
                dst = ir[15:11];
                case (ir[5:0])
                    cpu_pkg::FN_ADD: res = rs_v + rt_v;
                    cpu_pkg::FN_SUB: res = rs_v - rt_v;
                    cpu_pkg::FN_AND: res = rs_v & rt_v;
                    cpu_pkg::FN_SLT: res = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                    default:         dst = 0;
                endcase
            end
            cpu_pkg::OP_ADDI: begin
                dst = ir[20:16];
                res = addr;
            end
            cpu_pkg::OP_LW: begin
                push(addr, 1'b0, '0, tag);
                dst = ir[20:16];
                res = m_mem[addr[9:2]];
            end
            cpu_pkg::OP_SW: begin
                push(addr, 1'b1, rt_v, tag);
                m_mem[addr[9:2]] = rt_v;
            end
            cpu_pkg::OP_BEQ: if (rs_v == rt_v) m_pc = m_pc + {imm[29:0], 2'b00};
            cpu_pkg::OP_BNE: if (rs_v != rt_v) m_pc = m_pc + {imm[29:0], 2'b00};
            cpu_pkg::OP_J:   m_pc = {m_pc[31:28], ir[25:0], 2'b00};
            default: ;
        endcase
        if (dst != 0) m_regs[dst] = res;
        return m_pc == pc0;
    endfunction

    function automatic string test_name(int t);
        case (t)
            1:       return "reset";
            2:       return "arithmetic";
            3:       return "control flow";
            4:       return "load and store";
            5:       return "register zero";
            default: return "back-pressure";
        endcase
    endfunction

    task automatic report_tests();
        checks[6]++;
        if (waits == 0) begin
            errs[6]++;
            $display("No wait states were inserted by the memory model");
        end
        for (int t = 1; t <= 6; t++) begin
            $display("Test %0d %s: %0d checks, %0d errors", t, test_name(t), checks[t], errs[t]);
            error_count += errs[t];
            check_count += checks[t];
        end
    endtask

    task automatic compare_transfer();
        logic [2:0] t;
        t = exp_tag.pop_front();
        checks[t]++;
        if (seen == 0) begin
            checks[1]++;
            if (paddr !== RESET_PC) begin
                errs[1]++;
                $display("Error: paddr expected %h got %h on the first transfer",
                         RESET_PC, paddr);
            end
            if (pwrite !== 1'b0) begin
                errs[1]++;
                $display("Error: pwrite expected %h got %h on the first transfer",
                         1'b0, pwrite);
            end
        end
        if (paddr !== exp_addr[0]) begin
            errs[t]++;
            $display("Error: paddr expected %h got %h", exp_addr[0], paddr);
        end
        if (pwrite !== exp_write[0]) begin
            errs[t]++;
            $display("Error: pwrite expected %h got %h", exp_write[0], pwrite);
        end else if (exp_write[0] && pwdata !== exp_data[0]) begin
            errs[t]++;
            $display("Error: pwdata expected %h got %h", exp_data[0], pwdata);
        end
        void'(exp_addr.pop_front());
        void'(exp_write.pop_front());
        void'(exp_data.pop_front());
        seen++;
        if (seen == total) begin
            report_tests();
            done = 1'b1;
        end
    endtask

    initial begin
        done = 1'b0;
        timed_out = 1'b0;
        error_count = 0;
        check_count = 0;
        built = 1'b0;
        stalled = 1'b0;
        seen = 0;
        cycles = 0;
        waits = 0;
        for (int t = 0; t < 7; t++) begin
            checks[t] = 0;
            errs[t] = 0;
        end
        @(negedge reset);
        for (int i = 0; i < MEM_WORDS; i++) m_mem[i] = image[i];
        for (int r = 0; r < 32; r++) m_regs[r] = '0;
        m_pc = RESET_PC;
        for (int n = 0; n < 1000; n++) begin
            if (step_model()) break;
        end
        total = exp_addr.size();
        built = 1'b1;
    end

    // Sampled mid-cycle so that all pins are settled
    always @(negedge clk) begin
        if (reset) begin
            checks[1]++;
            if (psel !== 1'b0) begin
                errs[1]++;
                $display("Error: psel expected %h got %h during reset", 1'b0, psel);
            end
        end else if (built && !done) begin
            cycles++;
            if (stalled) begin
                checks[6]++;
                if (psel !== 1'b1 || penable !== 1'b1) begin
                    errs[6]++;
                    $display("Access phase ended while pready was low");
                end else if (paddr !== hold_addr) begin
                    errs[6]++;
                    $display("Error: paddr expected %h got %h during a stalled access",
                             hold_addr, paddr);
                end else if (pwrite !== hold_write) begin
                    errs[6]++;
                    $display("Error: pwrite expected %h got %h during a stalled access",
                             hold_write, pwrite);
                end else if (pwdata !== hold_data) begin
                    errs[6]++;
                    $display("Error: pwdata expected %h got %h during a stalled access",
                             hold_data, pwdata);
                end
            end
            stalled    = psel && penable && !pready;
            hold_addr  = paddr;
            hold_write = pwrite;
            hold_data  = pwdata;
            if (stalled) waits++;
            if (psel && penable && pready) compare_transfer();
            if (!done && cycles > total * 12) begin
                $display("Timeout after %0d cycles with %0d of %0d transfers seen",
                         cycles, seen, total);
                report_tests();
                timed_out = 1'b1;
                done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam cpu_pkg::word_t RESET_PC = 32'h100;
    localparam int MEM_WORDS = 256;

    logic clk;
    logic reset;
    logic psel, penable, pwrite, pready;
    cpu_pkg::word_t paddr, pwdata, prdata;

    cpu_pkg::word_t mem [MEM_WORDS];
    logic [2:0] tags [MEM_WORDS];      // Test number of each instruction word
    integer seed;
    int wait_left;
    int load_idx;
    logic done, timed_out;
    int error_count, check_count;

    mips_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    tb_checker #(.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS)) check0 (
        .clk (clk), .reset (reset),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .pready (pready),
        .image (mem), .tags (tags),
        .done (done), .timed_out (timed_out),
        .error_count (error_count), .check_count (check_count)
    );

    function automatic cpu_pkg::word_t enc_r(int rs, int rt, int rd, cpu_pkg::funct_t fn);
        return {cpu_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic cpu_pkg::word_t enc_i(cpu_pkg::opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic cpu_pkg::word_t enc_j(cpu_pkg::word_t target);
        return {cpu_pkg::OP_J, target[27:2]};
    endfunction

    task automatic emit(input cpu_pkg::word_t word, input logic [2:0] tag);
        mem[load_idx]  = word;
        tags[load_idx] = tag;
        load_idx++;
    endtask

    task automatic load_program();
        cpu_pkg::word_t here;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]  = {16'hd47a, 6'd0, i[7:0], 2'b00};   // Address tagged fill
            tags[i] = 3'd0;
        end
        mem[8'h90] = 32'h7fffffff;          // Data word at 0x240
        load_idx = RESET_PC[9:2];
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 1, 5), 3'd1);
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 2, -3), 3'd2);
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 3, 'h200), 3'd2);
        emit(enc_r(1, 2, 4, cpu_pkg::FN_ADD), 3'd2);
        emit(enc_i(cpu_pkg::OP_SW, 3, 4, 0), 3'd2);
        emit(enc_r(2, 1, 5, cpu_pkg::FN_SUB), 3'd2);
        emit(enc_i(cpu_pkg::OP_SW, 3, 5, 4), 3'd2);
        emit(enc_r(1, 2, 6, cpu_pkg::FN_AND), 3'd2);
        emit(enc_i(cpu_pkg::OP_SW, 3, 6, 8), 3'd2);
        emit(enc_r(2, 1, 7, cpu_pkg::FN_SLT), 3'd2);    // Negative less than positive
        emit(enc_i(cpu_pkg::OP_SW, 3, 7, 12), 3'd2);
        emit(enc_r(1, 2, 8, cpu_pkg::FN_SLT), 3'd2);
        emit(enc_i(cpu_pkg::OP_SW, 3, 8, 16), 3'd2);
        emit(enc_i(cpu_pkg::OP_LW, 3, 10, 'h40), 3'd2);
        emit(enc_i(cpu_pkg::OP_ADDI, 10, 11, 1), 3'd2);  // Wraps to 0x80000000
        emit(enc_i(cpu_pkg::OP_SW, 3, 11, 20), 3'd2);
        emit(enc_i(cpu_pkg::OP_LW, 3, 12, 'h44), 3'd4);
        emit(enc_i(cpu_pkg::OP_ADDI, 3, 13, 'h30), 3'd4);
        emit(enc_i(cpu_pkg::OP_SW, 13, 12, 8), 3'd4);
        emit(enc_r(1, 1, 0, cpu_pkg::FN_ADD), 3'd5);
        emit(enc_i(cpu_pkg::OP_SW, 3, 0, 24), 3'd5);
        emit(enc_i(cpu_pkg::OP_BEQ, 1, 1, 1), 3'd3);     // Taken
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 14, 99), 3'd3);
        emit(enc_i(cpu_pkg::OP_BEQ, 1, 2, 1), 3'd3);     // Not taken
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 15, 7), 3'd3);
        emit(enc_i(cpu_pkg::OP_BNE, 1, 2, 1), 3'd3);
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 15, 55), 3'd3);
        emit(enc_i(cpu_pkg::OP_BNE, 1, 1, 1), 3'd3);
        emit(enc_i(cpu_pkg::OP_ADDI, 15, 16, 1), 3'd3);
        emit(enc_i(cpu_pkg::OP_SW, 3, 16, 28), 3'd3);
        emit(enc_i(cpu_pkg::OP_SW, 3, 15, 32), 3'd3);
        here = {22'd0, load_idx[7:0], 2'b00};
        emit(enc_j(here + 32'd8), 3'd3);
        emit(enc_i(cpu_pkg::OP_ADDI, 0, 15, 0), 3'd3);
        emit(enc_j(here + 32'd8), 3'd3);                 // Spins here
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        seed    = 32'h029c1e3b;
        reset   = 1'b1;
        pready  = 1'b0;
        prdata  = '0;
        wait_left = 0;
        load_program();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    // APB slave with random wait states
    always @(posedge clk) begin
        int draw;
        if (reset) begin
            pready <= 1'b0;
        end else if (psel && !penable) begin
            draw = $random(seed) & 3;
            wait_left <= draw;
            pready    <= (draw == 0);
            prdata    <= mem[paddr[9:2]];
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
                if (pwrite) mem[paddr[9:2]] <= pwdata;
            end else begin
                wait_left <= wait_left - 1;
                if (wait_left == 1) pready <= 1'b1;
            end
        end
    end

    initial begin
        wait (done);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
cpu_pkg.sv
alu.sv
reg_file.sv
apb_master.sv
control_fsm.sv
datapath_regs.sv
mips_core.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= mips_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
